// ==== hw/key_load_cfg.svh ====
`ifndef KEY_LOAD_CFG_SVH
`define KEY_LOAD_CFG_SVH

// axi read port
`define KL_AXI_ADDR_W 64
`define KL_AXI_DATA_W 512
`define KL_BURST_LEN 64
`define KL_BURST_SIZE 6

// key addressing, base addresses are 4 KiB aligned
`define KL_KEY_ADDR_W 32
`define KL_BASE_LSB 12
`define KL_SEG_BYTES 4096
`define KL_SEG_SHIFT 8

// coefficient and data slot geometry
`define KL_COEFF_W 32
`define KL_SLOT_W 128

// limits and depths
`define KL_MAX_OUTSTANDING 31
`define KL_INST_PTR_W 3
`define KL_BUF_ADDR_W 9
`define KL_LEN_W 11
`define KL_DIGIT_W 5

`endif

// ==== hw/key_load_pkg.sv ====
`default_nettype none

`include "key_load_cfg.svh"

package key_load_pkg;

	typedef enum logic [2:0] {
		OP_INVALID        = 3'd0,
		OP_BOOTSTRAP      = 3'd1,
		OP_BOOTSTRAP_INIT = 3'd2,
		OP_RLWE_MULT_RGSW = 3'd3,
		OP_RLWESUBS       = 3'd4
	} opcode_e;

	// read-address side
	typedef enum logic [1:0] {
		AR_IDLE,
		AR_VALID,
		AR_CHECK_SEG,
		AR_CHECK_RLWE
	} ar_state_e;

	// read-data side
	typedef enum logic [1:0] {
		R_IDLE,
		R_WRITE,
		R_CHECK_SEG
	} r_state_e;

	typedef logic [`KL_KEY_ADDR_W-`KL_BASE_LSB-1:0] base_addr_t;
	// two coefficients per buffer line
	typedef logic [2*`KL_COEFF_W-1:0] line_t;
	typedef logic [`KL_BUF_ADDR_W-1:0] buf_addr_t;

endpackage

`default_nettype wire

// ==== hw/key_inst_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "key_load_cfg.svh"

module key_inst_queue import key_load_pkg::*; (
	input  wire logic clk,
	input  wire logic rstn,
	input  wire logic push,
	input  opcode_e   opcode,
	input  base_addr_t base_addr,
	input  wire logic pop,
	output logic      inst_full,
	output logic      not_empty,
	output opcode_e   head_opcode,
	output base_addr_t head_base
);

	localparam int DEPTH = 1 << `KL_INST_PTR_W;

	opcode_e    opcode_mem [DEPTH];
	base_addr_t base_mem [DEPTH];
	// extra msb marks the wrap
	logic [`KL_INST_PTR_W:0] wr_ptr;
	logic [`KL_INST_PTR_W:0] rd_ptr;

	assign not_empty = wr_ptr != rd_ptr;
	assign inst_full = (wr_ptr[`KL_INST_PTR_W-1:0] == rd_ptr[`KL_INST_PTR_W-1:0]) &&
		(wr_ptr[`KL_INST_PTR_W] != rd_ptr[`KL_INST_PTR_W]);

	assign head_opcode = opcode_mem[rd_ptr[`KL_INST_PTR_W-1:0]];
	assign head_base   = base_mem[rd_ptr[`KL_INST_PTR_W-1:0]];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				opcode_mem[i] <= OP_INVALID;
			end
		end else begin
			// a popped slot goes back to invalid
			if (pop) begin
				opcode_mem[rd_ptr[`KL_INST_PTR_W-1:0]] <= OP_INVALID;
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push) begin
				opcode_mem[wr_ptr[`KL_INST_PTR_W-1:0]] <= opcode;
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			base_mem[wr_ptr[`KL_INST_PTR_W-1:0]] <= base_addr;
		end
	end

	// host must respect inst_full, address engine must respect not_empty
	a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !inst_full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> not_empty);

endmodule

`default_nettype wire

// ==== hw/key_ar_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "key_load_cfg.svh"

module key_ar_engine import key_load_pkg::*; (
	input  wire logic                      clk,
	input  wire logic                      rstn,
	input  wire logic                      not_empty,
	input  opcode_e                        head_opcode,
	input  base_addr_t                     head_base,
	input  wire logic [`KL_LEN_W-1:0]      length,
	input  wire logic [`KL_DIGIT_W-1:0]    digit_g,
	input  wire logic                      arready,
	input  wire logic                      burst_done,
	output logic                           pop,
	output logic                           arvalid,
	output logic [`KL_AXI_ADDR_W-1:0]      araddr,
	output logic [7:0]                     arlen,
	output logic [2:0]                     arsize,
	output logic                           bursts_pending
);

	localparam int CNT_W  = $clog2(`KL_MAX_OUTSTANDING + 1);
	localparam int SEG_W  = `KL_LEN_W - `KL_SEG_SHIFT;
	localparam int RLWE_W = `KL_DIGIT_W + 1;
	localparam logic [CNT_W-1:0] MAX_OUT = `KL_MAX_OUTSTANDING;
	localparam logic [`KL_KEY_ADDR_W-1:0] SEG_STEP = `KL_SEG_BYTES;

	ar_state_e ar_state;
	opcode_e   opcode_q;
	logic [`KL_KEY_ADDR_W-1:0] addr_q;
	logic [SEG_W-1:0]  seg_cnt;
	logic [SEG_W-1:0]  num_seg;
	logic [RLWE_W-1:0] rlwe_cnt;
	logic [RLWE_W-1:0] rlwe_total;
	logic [CNT_W-1:0]  out_cnt;
	logic room;
	logic inc;
	logic seg_last;
	logic rlwe_last;

	assign arlen  = 8'(`KL_BURST_LEN - 1);
	assign arsize = 3'(`KL_BURST_SIZE);
	assign araddr = {{(`KL_AXI_ADDR_W - `KL_KEY_ADDR_W){1'b0}}, addr_q};

	// each 4 KiB segment carries 256 coefficients of both polys
	assign num_seg = length[`KL_LEN_W-1:`KL_SEG_SHIFT];

	always_comb begin
		case (opcode_q)
			OP_BOOTSTRAP, OP_BOOTSTRAP_INIT, OP_RLWE_MULT_RGSW: rlwe_total = {digit_g, 1'b0};
			OP_RLWESUBS: rlwe_total = {1'b0, digit_g};
			default: rlwe_total = RLWE_W'(1);
		endcase
	end

	assign room      = out_cnt != MAX_OUT;
	assign seg_last  = seg_cnt == num_seg - 1'b1;
	assign rlwe_last = rlwe_cnt == rlwe_total - 1'b1;
	assign pop       = (ar_state == AR_IDLE) && not_empty && room;
	assign arvalid   = ar_state == AR_VALID;
	assign inc       = arvalid && arready;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ar_state <= AR_IDLE;
			opcode_q <= OP_INVALID;
			seg_cnt  <= '0;
			rlwe_cnt <= '0;
		end else begin
			case (ar_state)
				AR_IDLE: begin
					if (pop) begin
						ar_state <= AR_VALID;
						opcode_q <= head_opcode;
						seg_cnt  <= '0;
						rlwe_cnt <= '0;
					end
				end
				AR_VALID: begin
					if (arready) ar_state <= AR_CHECK_SEG;
				end
				AR_CHECK_SEG: begin
					// hold here while the outstanding ceiling is reached
					if (room) begin
						if (seg_last) begin
							seg_cnt  <= '0;
							ar_state <= AR_CHECK_RLWE;
						end else begin
							seg_cnt  <= seg_cnt + 1'b1;
							ar_state <= AR_VALID;
						end
					end
				end
				AR_CHECK_RLWE: begin
					if (rlwe_last) begin
						ar_state <= AR_IDLE;
					end else if (room) begin
						rlwe_cnt <= rlwe_cnt + 1'b1;
						ar_state <= AR_VALID;
					end
				end
				default: ar_state <= AR_IDLE;
			endcase
		end
	end

	// address keeps counting across rlwes of one instruction
	always_ff @(posedge clk) begin
		if (pop) begin
			addr_q <= {head_base, {`KL_BASE_LSB{1'b0}}};
		end else if (ar_state == AR_CHECK_SEG && room) begin
			addr_q <= addr_q + SEG_STEP;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// outstanding bursts
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstn) begin
			out_cnt <= '0;
		end else begin
			case ({inc, burst_done})
				2'b10: out_cnt <= out_cnt + 1'b1;
				2'b01: out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt;
			endcase
		end
	end

	assign bursts_pending = out_cnt != '0;

	a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
		burst_done |-> out_cnt != '0);
	a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
		inc |-> out_cnt != MAX_OUT);

endmodule

`default_nettype wire

// ==== hw/key_r_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "key_load_cfg.svh"

module key_r_engine import key_load_pkg::*; (
	input  wire logic                     clk,
	input  wire logic                     rstn,
	input  wire logic                     bursts_pending,
	input  wire logic                     full0,
	input  wire logic                     full1,
	input  wire logic                     rvalid,
	input  wire logic [`KL_AXI_DATA_W-1:0] rdata,
	input  wire logic                     rlast,
	input  wire logic [`KL_LEN_W-1:0]     length,
	output logic                          rready,
	output logic                          burst_done,
	output logic                          wr_en,
	output buf_addr_t                     wr_addr_a,
	output buf_addr_t                     wr_addr_b,
	output line_t                         wr_data0_a,
	output line_t                         wr_data0_b,
	output line_t                         wr_data1_a,
	output line_t                         wr_data1_b,
	output logic                          commit
);

	localparam int SEG_W = `KL_LEN_W - `KL_SEG_SHIFT;

	r_state_e r_state;
	logic [SEG_W-1:0] seg_cnt;
	logic [SEG_W-1:0] num_seg;
	logic beat;
	logic seg_last;

	// a slot holds two 64-bit words, the coefficient sits in the low half of each
	function automatic line_t slot_to_line(input logic [`KL_SLOT_W-1:0] slot);
		return {slot[2*`KL_COEFF_W +: `KL_COEFF_W], slot[0 +: `KL_COEFF_W]};
	endfunction

	// interleaved layout, lane0 a/b then lane1 a/b
	assign wr_data0_a = slot_to_line(rdata[0*`KL_SLOT_W +: `KL_SLOT_W]);
	assign wr_data0_b = slot_to_line(rdata[1*`KL_SLOT_W +: `KL_SLOT_W]);
	assign wr_data1_a = slot_to_line(rdata[2*`KL_SLOT_W +: `KL_SLOT_W]);
	assign wr_data1_b = slot_to_line(rdata[3*`KL_SLOT_W +: `KL_SLOT_W]);

	assign num_seg    = length[`KL_LEN_W-1:`KL_SEG_SHIFT];
	assign seg_last   = seg_cnt == num_seg - 1'b1;
	assign rready     = r_state == R_WRITE;
	assign beat       = rvalid && rready;
	assign wr_en      = beat;
	assign burst_done = beat && rlast;
	assign commit     = (r_state == R_CHECK_SEG) && seg_last;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			r_state   <= R_IDLE;
			seg_cnt   <= '0;
			wr_addr_a <= buf_addr_t'(0);
			wr_addr_b <= buf_addr_t'(1);
		end else begin
			case (r_state)
				R_IDLE: begin
					seg_cnt   <= '0;
					wr_addr_a <= buf_addr_t'(0);
					wr_addr_b <= buf_addr_t'(1);
					// both lanes must be released before the next rlwe
					if (bursts_pending && !full0 && !full1) r_state <= R_WRITE;
				end
				R_WRITE: begin
					if (beat) begin
						wr_addr_a <= wr_addr_a + 2'd2;
						wr_addr_b <= wr_addr_b + 2'd2;
						if (rlast) r_state <= R_CHECK_SEG;
					end
				end
				R_CHECK_SEG: begin
					if (seg_last) begin
						seg_cnt <= '0;
						r_state <= R_IDLE;
					end else begin
						seg_cnt <= seg_cnt + 1'b1;
						r_state <= R_WRITE;
					end
				end
				default: r_state <= R_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/key_poly_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "key_load_cfg.svh"

module key_poly_buffer import key_load_pkg::*; (
	input  wire logic clk,
	input  wire logic rstn,
	input  wire logic wr_en,
	input  buf_addr_t wr_addr_a,
	input  buf_addr_t wr_addr_b,
	input  line_t     wr_data_a,
	input  line_t     wr_data_b,
	input  wire logic commit,
	input  buf_addr_t rd_addr,
	input  wire logic rd_done,
	output line_t     rd_data,
	output logic      full
);

	localparam int LINES = 1 << `KL_BUF_ADDR_W;

	// poly a on even lines, poly b on odd lines
	line_t mem [LINES];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr_a] <= wr_data_a;
			mem[wr_addr_b] <= wr_data_b;
		end
		rd_data <= mem[rd_addr];
	end

	// one rlwe held until the consumer lets go
	always_ff @(posedge clk) begin
		if (!rstn) begin
			full <= 1'b0;
		end else if (commit) begin
			full <= 1'b1;
		end else if (rd_done) begin
			full <= 1'b0;
		end
	end

	a_done_when_full: assert property (@(posedge clk) disable iff (!rstn) rd_done |-> full);

endmodule

`default_nettype wire

// ==== hw/key_load_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "key_load_cfg.svh"

module key_load_top import key_load_pkg::*; (
	input  wire logic                      clk,
	input  wire logic                      rstn,
	input  wire logic                      push,
	input  opcode_e                        opcode,
	input  base_addr_t                     base_addr,
	input  wire logic [`KL_LEN_W-1:0]      length,
	input  wire logic [`KL_DIGIT_W-1:0]    digit_g,
	input  wire logic                      arready,
	input  wire logic                      rvalid,
	input  wire logic [`KL_AXI_DATA_W-1:0] rdata,
	input  wire logic                      rlast,
	input  buf_addr_t                      rd_addr0,
	input  wire logic                      rd_done0,
	input  buf_addr_t                      rd_addr1,
	input  wire logic                      rd_done1,
	output logic                           inst_full,
	output logic                           inst_empty,
	output logic                           arvalid,
	output logic [`KL_AXI_ADDR_W-1:0]      araddr,
	output logic [7:0]                     arlen,
	output logic [2:0]                     arsize,
	output logic                           rready,
	output line_t                          rd_data0,
	output logic                           full0,
	output line_t                          rd_data1,
	output logic                           full1
);

	logic       pop;
	logic       not_empty;
	opcode_e    head_opcode;
	base_addr_t head_base;
	logic       burst_done;
	logic       bursts_pending;
	logic       wr_en;
	logic       commit;
	buf_addr_t  wr_addr_a;
	buf_addr_t  wr_addr_b;
	line_t      wr_data0_a;
	line_t      wr_data0_b;
	line_t      wr_data1_a;
	line_t      wr_data1_b;

	assign inst_empty = !not_empty;

	////////////////////////////////////////////////////////////////////////////
	// instruction queue and the two read engines
	////////////////////////////////////////////////////////////////////////////

	key_inst_queue u_queue (
		.clk, .rstn, .push, .opcode, .base_addr, .pop,
		.inst_full, .not_empty, .head_opcode, .head_base
	);

	key_ar_engine u_ar (
		.clk, .rstn, .not_empty, .head_opcode, .head_base, .length, .digit_g,
		.arready, .burst_done, .pop, .arvalid, .araddr, .arlen, .arsize,
		.bursts_pending
	);

	key_r_engine u_r (
		.clk, .rstn, .bursts_pending, .full0, .full1, .rvalid, .rdata, .rlast,
		.length, .rready, .burst_done, .wr_en, .wr_addr_a, .wr_addr_b,
		.wr_data0_a, .wr_data0_b, .wr_data1_a, .wr_data1_b, .commit
	);

	////////////////////////////////////////////////////////////////////////////
	// lane buffers, both written in the same cycle
	////////////////////////////////////////////////////////////////////////////

	key_poly_buffer lane0_buf (
		.clk, .rstn, .wr_en, .wr_addr_a, .wr_addr_b,
		.wr_data_a(wr_data0_a), .wr_data_b(wr_data0_b), .commit,
		.rd_addr(rd_addr0), .rd_done(rd_done0), .rd_data(rd_data0), .full(full0)
	);

	key_poly_buffer lane1_buf (
		.clk, .rstn, .wr_en, .wr_addr_a, .wr_addr_b,
		.wr_data_a(wr_data1_a), .wr_data_b(wr_data1_b), .commit,
		.rd_addr(rd_addr1), .rd_done(rd_done1), .rd_data(rd_data1), .full(full1)
	);

endmodule

`default_nettype wire

// ==== sim/ddr_read_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "key_load_cfg.svh"

module ddr_read_model #(
	parameter logic [31:0] SEED = 32'h1
) (
	input  wire logic                      clk,
	input  wire logic                      rstn,
	input  wire logic                      hold_ar,
	input  wire logic                      hold_r,
	input  wire logic                      arvalid,
	input  wire logic [`KL_AXI_ADDR_W-1:0] araddr,
	input  wire logic                      rready,
	output logic                           arready,
	output logic                           rvalid,
	output logic [`KL_AXI_DATA_W-1:0]      rdata,
	output logic                           rlast
);

	// accepted bursts waiting for their data, oldest first
	logic [31:0] burst_q [$];
	int          beat;
	logic        r_fire;
	logic        seeded;

	// word w of beat k carries the low 32 bits of addr + 64k + 8w
	function automatic logic [`KL_AXI_DATA_W-1:0] beat_data(input logic [31:0] addr,
			input int k);
		logic [`KL_AXI_DATA_W-1:0] d;
		logic [31:0] v;
		for (int w = 0; w < `KL_AXI_DATA_W / 64; w++) begin
			v = addr + 32'(64 * k + 8 * w);
			d[64*w +: 64] = {~v, v};
		end
		return d;
	endfunction

	initial begin
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = '0;
		rlast   = 1'b0;
		seeded  = 1'b0;
		beat    = 0;
		r_fire  = 1'b0;
	end

	// everything moves on the falling edge, the DUT samples on the rising one
	always @(negedge clk) begin
		if (!rstn) begin
			if (!seeded) begin
				void'($urandom(SEED));
				seeded = 1'b1;
			end
			arready = 1'b0;
			rvalid  = 1'b0;
			rlast   = 1'b0;
			beat    = 0;
			r_fire  = 1'b0;
			burst_q.delete();
		end else begin
			// retire the beat taken at the last rising edge
			if (r_fire) begin
				if (beat == `KL_BURST_LEN - 1) begin
					beat = 0;
					void'(burst_q.pop_front());
				end else begin
					beat++;
				end
			end
			// a beat still waiting for rready keeps rvalid up
			if (!(rvalid && !r_fire)) begin
				rvalid = (burst_q.size() != 0) && !hold_r && ($urandom % 8 != 0);
			end
			if (burst_q.size() != 0) begin
				rdata = beat_data(burst_q[0], beat);
			end
			rlast  = rvalid && (beat == `KL_BURST_LEN - 1);
			r_fire = rvalid && rready;

			// new requests only after the data side, so data never leads its address
			arready = !hold_ar && ($urandom % 4 != 0);
			if (arvalid && arready) begin
				burst_q.push_back(araddr[31:0]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_key_load.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "key_load_cfg.svh"

module tb_key_load import key_load_pkg::*; ();

	// 51 bursts with their transfers and the readback of 128 lines each
	localparam int TOTAL_BURSTS = 51;
	localparam int BURST_CYCLES = 80 + 128;
	localparam int CYCLE_LIMIT  = TOTAL_BURSTS * BURST_CYCLES + 2000;

	logic clk;
	logic rstn;
	logic push;
	opcode_e opcode;
	base_addr_t base_addr;
	logic [`KL_LEN_W-1:0] length;
	logic [`KL_DIGIT_W-1:0] digit_g;
	logic arready;
	logic rvalid;
	logic [`KL_AXI_DATA_W-1:0] rdata;
	logic rlast;
	buf_addr_t rd_addr0;
	buf_addr_t rd_addr1;
	logic rd_done0;
	logic rd_done1;
	logic inst_full;
	logic inst_empty;
	logic arvalid;
	logic [`KL_AXI_ADDR_W-1:0] araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic rready;
	line_t rd_data0;
	line_t rd_data1;
	logic full0;
	logic full1;
	logic hold_ar;
	logic hold_r;
	logic rd_en;

	// expected requests and rlwes filled in as instructions are pushed
	logic [31:0] exp_addr [64];
	logic [31:0] exp_base [32];
	int exp_lines [32];
	int exp_reqs = 0;
	int exp_rlwes = 0;
	int ar_idx;
	int rl_idx = 0;
	int outstanding;
	logic [31:0] rlwe_base = '0;
	int errors = 0;
	int mark = 0;
	int n_pass = 0;
	int n_fail = 0;
	int cycles = 0;

	key_load_top DUT (
		.clk, .rstn, .push, .opcode, .base_addr, .length, .digit_g,
		.arready, .rvalid, .rdata, .rlast, .rd_addr0, .rd_done0, .rd_addr1, .rd_done1,
		.inst_full, .inst_empty, .arvalid, .araddr, .arlen, .arsize, .rready,
		.rd_data0, .full0, .rd_data1, .full1
	);

	ddr_read_model #(.SEED(32'ha83c)) u_ddr (
		.clk, .rstn, .hold_ar, .hold_r, .arvalid, .araddr, .rready,
		.arready, .rvalid, .rdata, .rlast
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// reference model of the request and burst bookkeeping
	////////////////////////////////////////////////////////////////////////////

	function automatic int rlwes_per_inst(input opcode_e op, input int g);
		case (op)
			OP_BOOTSTRAP, OP_BOOTSTRAP_INIT, OP_RLWE_MULT_RGSW: return 2 * g;
			OP_RLWESUBS: return g;
			default: return 1;
		endcase
	endfunction

	// line 2j holds slot 2*lane of beat j and line 2j+1 holds slot 2*lane+1
	function automatic line_t exp_line(input logic [31:0] base, input int lane,
			input buf_addr_t a);
		logic [31:0] c0;
		int j;
		int slot;
		j = int'(a) / 2;
		slot = 2 * lane + int'(a[0]);
		c0 = base + 32'(64 * j + 16 * slot);
		return {c0 + 32'd8, c0};
	endfunction

	always @(posedge clk) begin
		if (!rstn) begin
			ar_idx      <= 0;
			outstanding <= 0;
		end else begin
			if (arvalid && arready) ar_idx <= ar_idx + 1;
			outstanding <= outstanding + int'(arvalid && arready) -
				int'(rvalid && rready && rlast);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		$display("** Error %0t: %s", $time, msg);
		errors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk) $rose(rstn) |->
		!arvalid && !rready && !inst_full && !full0 && !full1 && inst_empty)
		else report_error("outputs not at their reset values");
	a_ar_addr: assert property (@(posedge clk) disable iff (!rstn) arvalid && arready |->
		araddr == 64'(exp_addr[ar_idx]) && arlen == 8'd63 && arsize == 3'd6)
		else report_error($sformatf("request araddr %h arlen %0d arsize %0d", araddr,
			arlen, arsize));
	a_ar_extra: assert property (@(posedge clk) disable iff (!rstn)
		arvalid && arready |-> ar_idx < exp_reqs)
		else report_error("more address requests than the pushed instructions need");
	a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else report_error("arvalid or araddr changed before the transfer");
	a_no_beat_full: assert property (@(posedge clk) disable iff (!rstn)
		full0 || full1 |-> !(rvalid && rready))
		else report_error("beat accepted while a lane buffer is full");
	a_lanes_together: assert property (@(posedge clk) disable iff (!rstn) full0 == full1)
		else report_error("lane full flags differ");
	a_extra_rlwe: assert property (@(posedge clk) disable iff (!rstn)
		$rose(full0) |-> rl_idx < exp_rlwes)
		else report_error("more rlwes committed than expected");
	a_out_max: assert property (@(posedge clk) disable iff (!rstn)
		outstanding <= `KL_MAX_OUTSTANDING)
		else report_error($sformatf("%0d bursts outstanding", outstanding));
	a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !inst_full)
		else report_error("push while the queue is full");
	a_lane0_data: assert property (@(posedge clk) disable iff (!rstn)
		rd_en |=> rd_data0 == exp_line(rlwe_base, 0, $past(rd_addr0)))
		else report_error($sformatf("lane 0 line data %h", rd_data0));
	a_lane1_data: assert property (@(posedge clk) disable iff (!rstn)
		rd_en |=> rd_data1 == exp_line(rlwe_base, 1, $past(rd_addr1)))
		else report_error($sformatf("lane 1 line data %h", rd_data1));

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks enter and leave on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic push_inst(input opcode_e op, input base_addr_t base, input int g,
			input int len);
		int nr;
		logic [31:0] addr;
		nr = rlwes_per_inst(op, g);
		addr = {base, 12'h000};
		for (int r = 0; r < nr; r++) begin
			exp_base[exp_rlwes] = addr;
			exp_lines[exp_rlwes] = len / 2;
			exp_rlwes++;
			for (int s = 0; s < len / 256; s++) begin
				exp_addr[exp_reqs] = addr;
				exp_reqs++;
				addr = addr + 32'd4096;
			end
		end
		push = 1'b1;
		opcode = op;
		base_addr = base;
		length = `KL_LEN_W'(len);
		digit_g = `KL_DIGIT_W'(g);
		@(negedge clk);
		push = 1'b0;
	endtask

	// read every used line of both lanes and then release them
	task automatic drain_rlwes(input int count);
		int lines;
		for (int r = 0; r < count; r++) begin
			while (!(full0 && full1)) @(negedge clk);
			rlwe_base = exp_base[rl_idx];
			lines = exp_lines[rl_idx];
			for (int a = 0; a < lines; a++) begin
				rd_en = 1'b1;
				rd_addr0 = buf_addr_t'(a);
				rd_addr1 = buf_addr_t'(a);
				@(negedge clk);
			end
			rd_en = 1'b0;
			rd_done0 = 1'b1;
			rd_done1 = 1'b1;
			@(negedge clk);
			rd_done0 = 1'b0;
			rd_done1 = 1'b0;
			rl_idx++;
		end
	endtask

	task automatic end_test(input string name);
		repeat (20) @(negedge clk);
		assert (ar_idx == exp_reqs)
			else report_error($sformatf("%0d requests, expected %0d", ar_idx, exp_reqs));
		assert (rl_idx == exp_rlwes)
			else report_error($sformatf("%0d rlwes read, expected %0d", rl_idx, exp_rlwes));
		if (errors == mark) begin
			$display("test %s: ok", name);
			n_pass++;
		end else begin
			$display("test %s: FAILED with %0d errors", name, errors - mark);
			n_fail++;
		end
		mark = errors;
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		push = 1'b0;
		opcode = OP_INVALID;
		base_addr = '0;
		length = `KL_LEN_W'(256);
		digit_g = `KL_DIGIT_W'(1);
		rd_addr0 = '0;
		rd_addr1 = '0;
		rd_done0 = 1'b0;
		rd_done1 = 1'b0;
		rd_en = 1'b0;
		hold_ar = 1'b0;
		hold_r = 1'b0;
		repeat (2) @(negedge clk);
		rstn = 1'b1;
		@(negedge clk);
		end_test("reset");

		push_inst(OP_RLWESUBS, 20'h00010, 1, 256);
		drain_rlwes(1);
		end_test("single_rlwe");

		push_inst(OP_BOOTSTRAP, 20'h00100, 2, 512);
		drain_rlwes(4);
		end_test("bootstrap_requests");

		// digit_g is ignored for an unknown opcode
		push_inst(OP_INVALID, 20'h00200, 3, 256);
		drain_rlwes(1);
		end_test("unknown_opcode");

		// first instruction parks the engine at arvalid while the next eight fill the queue
		hold_ar = 1'b1;
		push_inst(OP_RLWESUBS, 20'h00300, 1, 256);
		while (!inst_empty) @(negedge clk);
		for (int k = 0; k < 8; k++) begin
			push_inst(OP_RLWESUBS, 20'h00310 + 20'(k), 1, 256);
			assert (inst_full == (k == 7))
				else report_error($sformatf("inst_full %b after push %0d", inst_full, k + 1));
		end
		assert (arvalid) else report_error("arvalid dropped while arready is low");
		hold_ar = 1'b0;
		drain_rlwes(9);
		end_test("queue_backpressure");

		// stall the data side until the address engine reaches its ceiling
		hold_r = 1'b1;
		push_inst(OP_BOOTSTRAP_INIT, 20'h01000, 4, 1024);
		while (outstanding < `KL_MAX_OUTSTANDING) @(negedge clk);
		repeat (8) @(negedge clk);
		assert (outstanding == `KL_MAX_OUTSTANDING && !arvalid)
			else report_error($sformatf("%0d outstanding, arvalid %b at the ceiling",
				outstanding, arvalid));
		hold_r = 1'b0;
		drain_rlwes(8);
		end_test("outstanding_limit");

		$display("summary: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
		if (errors == 0 && n_fail == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/key_load_pkg.sv
hw/key_inst_queue.sv
hw/key_ar_engine.sv
hw/key_r_engine.sv
hw/key_poly_buffer.sv
hw/key_load_top.sv
sim/ddr_read_model.sv
sim/tb_key_load.sv

// ==== Bender.yml ====
package:
  name: key_load

sources:
  - include_dirs:
      - hw
    files:
      - hw/key_load_pkg.sv
      - hw/key_inst_queue.sv
      - hw/key_ar_engine.sv
      - hw/key_r_engine.sv
      - hw/key_poly_buffer.sv
      - hw/key_load_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/ddr_read_model.sv
      - sim/tb_key_load.sv
